//--- logic/fe_pkg.sv
`default_nettype none

package fe_pkg;

  // decoded operation
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_ADDI,
    OP_LD,
    OP_ST,
    OP_BEQ,
    OP_BL,
    OP_NONE
  } op_e;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_ADDR,
    FS_DATA
  } fetch_state_e;

  // index zero means no register
  typedef struct packed {
    logic [4:0] rs0;
    logic [4:0] rs1;
    logic [4:0] rd;
  } reg_info_t;

  // axi4-lite read address channel
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axil_ar_t;

  // axi4-lite read data channel
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axil_r_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // one fetched and decoded instruction
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    op_e         op;
    reg_info_t   ri;
    logic        ine;
    logic        ferr;
  } fetch_pkt_t;

endpackage

`default_nettype wire

//--- logic/fetch_ctrl.sv
`default_nettype none

module fetch_ctrl #(
  parameter logic [31:0] RESET_PC = 32'h0000_0100
) (
  input  logic               clk,
  input  logic               rst_n,
  input  fe_pkg::redirect_t  redirect_i,
  input  logic               credit_ok_i,
  output logic               issue_o,
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  output fe_pkg::axil_ar_t   m_ar_o,
  input  logic               m_rvalid_i,
  output logic               m_rready_o,
  input  fe_pkg::axil_r_t    m_r_i,
  output logic               push_o,
  output fe_pkg::fetch_pkt_t pkt_o
);

  fe_pkg::fetch_state_e state_q;
  fe_pkg::fetch_state_e state_d;
  logic [31:0] pc_q;
  logic [31:0] pc_d;
  logic [31:0] ar_addr_q;
  logic        stale_q;
  logic        stale_set;
  logic        ar_xfer;
  logic        r_xfer;

  assign m_arvalid_o = (state_q == fe_pkg::FS_ADDR);
  assign m_rready_o  = (state_q == fe_pkg::FS_DATA);
  assign ar_xfer     = m_arvalid_o && m_arready_i;
  assign r_xfer      = m_rvalid_i && m_rready_o;

  // stale reads hold no slot
  assign issue_o = ar_xfer && !stale_q;
  assign push_o  = r_xfer && !stale_q && !redirect_i.valid;

  // address is committed once arvalid is up, so a redirect only marks it stale
  assign stale_set = redirect_i.valid && (m_arvalid_o || (m_rready_o && !r_xfer));

  always_comb
  begin
    m_ar_o.addr = ar_addr_q;
    m_ar_o.prot = 3'b000;
  end

  always_comb
  begin
    pkt_o      = '0;
    pkt_o.pc   = ar_addr_q;
    pkt_o.inst = m_r_i.data;
    pkt_o.ferr = (m_r_i.resp != 2'b00);
  end

  always_comb
  begin
    pc_d = pc_q;
    if (redirect_i.valid)
      pc_d = redirect_i.target;
    else if (push_o)
      pc_d = pc_q + 32'd4;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      fe_pkg::FS_IDLE:
        if (credit_ok_i && !redirect_i.valid)
          state_d = fe_pkg::FS_ADDR;
      fe_pkg::FS_ADDR:
        if (ar_xfer)
          state_d = fe_pkg::FS_DATA;
      fe_pkg::FS_DATA:
        if (r_xfer)
        begin
          if (credit_ok_i && !redirect_i.valid)
            state_d = fe_pkg::FS_ADDR;
          else
            state_d = fe_pkg::FS_IDLE;
        end
      default:
        state_d = fe_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q <= fe_pkg::FS_IDLE;
      pc_q    <= RESET_PC;
      stale_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (stale_set)
        stale_q <= 1'b1;
      else if (r_xfer)
        stale_q <= 1'b0;
    end
  end

  // latch request address on entry to the address phase
  always_ff @(posedge clk)
  begin
    if (state_d == fe_pkg::FS_ADDR && state_q != fe_pkg::FS_ADDR)
      ar_addr_q <= pc_d;
  end

  ar_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_ar_o));

  // redirect targets from the back end must be word aligned too
  pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/slot_credit.sv
`default_nettype none

module slot_credit #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic issue_i,
  input  logic pop_i,
  input  logic flush_i,
  output logic credit_ok_o
);

  localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);
  localparam logic [CW-1:0] DEPTH_C = CW'(QUEUE_DEPTH);

  // reserved by a read in flight plus held in the queue
  logic [CW-1:0] count_q;

  assign credit_ok_o = (count_q < DEPTH_C);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      count_q <= '0;
    else if (flush_i)
      count_q <= '0;
    else
    begin
      case ({issue_i, pop_i})
        2'b10:   count_q <= count_q + CW'(1);
        2'b01:   count_q <= count_q - CW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // holds only if fetch waits for credit before each request
  count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    count_q <= DEPTH_C);

endmodule

`default_nettype wire

//--- logic/inst_decode.sv
`default_nettype none

module inst_decode (
  input  fe_pkg::fetch_pkt_t pkt_i,
  output fe_pkg::fetch_pkt_t pkt_o
);

  logic [5:0] opc;
  logic [4:0] f_rd;
  logic [4:0] f_rj;
  logic [4:0] f_rk;
  fe_pkg::op_e op;
  logic        illegal;

  assign opc  = pkt_i.inst[31:26];
  assign f_rd = pkt_i.inst[4:0];
  assign f_rj = pkt_i.inst[9:5];
  assign f_rk = pkt_i.inst[14:10];

  // opcode field to operation
  always_comb
  begin
    illegal = 1'b0;
    case (opc)
      6'h01:   op = fe_pkg::OP_ADD;
      6'h02:   op = fe_pkg::OP_SUB;
      6'h03:   op = fe_pkg::OP_AND;
      6'h04:   op = fe_pkg::OP_OR;
      6'h05:   op = fe_pkg::OP_ADDI;
      6'h06:   op = fe_pkg::OP_LD;
      6'h07:   op = fe_pkg::OP_ST;
      6'h08:   op = fe_pkg::OP_BEQ;
      6'h09:   op = fe_pkg::OP_BL;
      default:
      begin
        op      = fe_pkg::OP_NONE;
        illegal = 1'b1;
      end
    endcase
  end

  always_comb
  begin
    pkt_o     = pkt_i;
    pkt_o.op  = fe_pkg::OP_NONE;
    pkt_o.ri  = '0;
    pkt_o.ine = 1'b0;
    // bus error wins over decode
    if (!pkt_i.ferr)
    begin
      pkt_o.op  = op;
      pkt_o.ine = illegal;
      case (op)
        fe_pkg::OP_ADD, fe_pkg::OP_SUB, fe_pkg::OP_AND, fe_pkg::OP_OR:
        begin
          pkt_o.ri.rs0 = f_rj;
          pkt_o.ri.rs1 = f_rk;
          pkt_o.ri.rd  = f_rd;
        end
        fe_pkg::OP_ADDI, fe_pkg::OP_LD:
        begin
          pkt_o.ri.rs0 = f_rj;
          pkt_o.ri.rd  = f_rd;
        end
        // store data and second compare operand sit in the rd field
        fe_pkg::OP_ST, fe_pkg::OP_BEQ:
        begin
          pkt_o.ri.rs0 = f_rj;
          pkt_o.ri.rs1 = f_rd;
        end
        fe_pkg::OP_BL:
          pkt_o.ri.rd = 5'd1;
        default:
          pkt_o.ri = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/inst_queue.sv
`default_nettype none

module inst_queue #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush_i,
  input  logic               push_i,
  input  fe_pkg::fetch_pkt_t push_pkt_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output fe_pkg::fetch_pkt_t out_pkt_o,
  output logic               pop_o
);

  localparam int unsigned AW = $clog2(QUEUE_DEPTH);
  localparam logic [AW:0] DEPTH_C = (AW + 1)'(QUEUE_DEPTH);

  fe_pkg::fetch_pkt_t mem_q [QUEUE_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [AW:0]   count_q;
  logic          full;

  assign full        = (count_q == DEPTH_C);
  assign out_valid_o = (count_q != '0);
  assign out_pkt_o   = mem_q[rd_ptr_q];
  assign pop_o       = out_valid_o && out_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + AW'(1);
      if (pop_o)
        rd_ptr_q <= rd_ptr_q + AW'(1);
      case ({push_i, pop_o})
        2'b10:   count_q <= count_q + (AW + 1)'(1);
        2'b01:   count_q <= count_q - (AW + 1)'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push_i && !flush_i)
      mem_q[wr_ptr_q] <= push_pkt_i;
  end

  // slot credit upstream must keep fetch from overrunning the queue
  no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i && !flush_i |-> !full);

endmodule

`default_nettype wire

//--- logic/fe_top.sv
`default_nettype none

module fe_top #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter logic [31:0] RESET_PC    = 32'h0000_0100
) (
  input  logic               clk,
  input  logic               rst_n,
  input  fe_pkg::redirect_t  redirect_i,
  output logic               m_arvalid_o,
  input  logic               m_arready_i,
  output fe_pkg::axil_ar_t   m_ar_o,
  input  logic               m_rvalid_i,
  output logic               m_rready_o,
  input  fe_pkg::axil_r_t    m_r_i,
  output logic               inst_valid_o,
  input  logic               inst_ready_i,
  output fe_pkg::fetch_pkt_t inst_pkt_o
);

  logic               issue;
  logic               credit_ok;
  logic               push;
  logic               pop;
  fe_pkg::fetch_pkt_t raw_pkt;
  fe_pkg::fetch_pkt_t dec_pkt;

  fetch_ctrl #(
    .RESET_PC(RESET_PC)
  ) i_fetch_ctrl (
    .clk(clk),
    .rst_n(rst_n),
    .redirect_i(redirect_i),
    .credit_ok_i(credit_ok),
    .issue_o(issue),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_ar_o(m_ar_o),
    .m_rvalid_i(m_rvalid_i),
    .m_rready_o(m_rready_o),
    .m_r_i(m_r_i),
    .push_o(push),
    .pkt_o(raw_pkt)
  );

  slot_credit #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_slot_credit (
    .clk(clk),
    .rst_n(rst_n),
    .issue_i(issue),
    .pop_i(pop),
    .flush_i(redirect_i.valid),
    .credit_ok_o(credit_ok)
  );

  inst_decode i_inst_decode (
    .pkt_i(raw_pkt),
    .pkt_o(dec_pkt)
  );

  inst_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_inst_queue (
    .clk(clk),
    .rst_n(rst_n),
    .flush_i(redirect_i.valid),
    .push_i(push),
    .push_pkt_i(dec_pkt),
    .out_valid_o(inst_valid_o),
    .out_ready_i(inst_ready_i),
    .out_pkt_o(inst_pkt_o),
    .pop_o(pop)
  );

endmodule

`default_nettype wire

//--- verification/axil_rom_model.sv
`default_nettype none

module axil_rom_model (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             arvalid_i,
  output logic             arready_o,
  input  fe_pkg::axil_ar_t ar_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output fe_pkg::axil_r_t  r_o
);

  // one word per address below the error region
  logic [31:0] prog [1024];
  logic [31:0] lfsr_q;
  logic [31:0] lfsr_1;
  logic [31:0] lfsr_2;
  logic [31:0] addr_q;
  logic [1:0]  wait_q;
  logic        busy_q;

  // fibonacci with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  assign lfsr_1    = lfsr_step(lfsr_q);
  assign lfsr_2    = lfsr_step(lfsr_1);
  assign arready_o = !busy_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      lfsr_q   <= 32'h753e_8185;
      busy_q   <= 1'b0;
      rvalid_o <= 1'b0;
      wait_q   <= 2'd0;
      addr_q   <= '0;
      r_o      <= '0;
    end
    else if (arvalid_i && arready_o)
    begin
      // two delay bits take two steps
      lfsr_q <= lfsr_2;
      wait_q <= {lfsr_1[0], lfsr_2[0]};
      addr_q <= ar_i.addr;
      busy_q <= 1'b1;
    end
    else if (busy_q && !rvalid_o)
    begin
      if (wait_q != 2'd0)
        wait_q <= wait_q - 2'd1;
      else
      begin
        rvalid_o <= 1'b1;
        // slave error above the table with data read as zero
        if (addr_q >= 32'h0000_1000)
        begin
          r_o.data <= '0;
          r_o.resp <= 2'b10;
        end
        else
        begin
          r_o.data <= prog[addr_q[11:2]];
          r_o.resp <= 2'b00;
        end
      end
    end
    else if (rvalid_o && rready_i)
    begin
      rvalid_o <= 1'b0;
      busy_q   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_fe_top.sv
`default_nettype none

module tb_fe_top;

  localparam int unsigned QUEUE_DEPTH = 4;
  localparam logic [31:0] RESET_PC    = 32'h0000_0100;
  // 8, 10, 12, 8 and 5 packets awaited by the tests
  localparam int EXPECTED_PKTS = 43;
  localparam int MAX_CYCLES    = 40 * EXPECTED_PKTS;

  logic               clk;
  logic               rst_n;
  fe_pkg::redirect_t  redirect;
  logic               arvalid;
  logic               arready;
  fe_pkg::axil_ar_t   ar;
  logic               rvalid;
  logic               rready;
  fe_pkg::axil_r_t    r;
  logic               inst_valid;
  logic               inst_ready;
  fe_pkg::fetch_pkt_t inst_pkt;

  fe_pkg::fetch_pkt_t got [$];
  fe_pkg::fetch_pkt_t case_exp [10];
  int                 errors;
  int                 checks;
  int                 cycles;
  int                 ar_seen;
  logic [31:0]        ar_floor;

  fe_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RESET_PC(RESET_PC)
  ) i_fe_top (
    .clk(clk),
    .rst_n(rst_n),
    .redirect_i(redirect),
    .m_arvalid_o(arvalid),
    .m_arready_i(arready),
    .m_ar_o(ar),
    .m_rvalid_i(rvalid),
    .m_rready_o(rready),
    .m_r_i(r),
    .inst_valid_o(inst_valid),
    .inst_ready_i(inst_ready),
    .inst_pkt_o(inst_pkt)
  );

  axil_rom_model i_axil_rom (
    .clk(clk),
    .rst_n(rst_n),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .ar_i(ar),
    .rvalid_o(rvalid),
    .rready_i(rready),
    .r_o(r)
  );

  always #50 clk = ~clk;

  // bus and output monitor
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (arvalid && arready)
      begin
        check_ar(ar);
        if (ar.addr >= ar_floor)
          ar_seen = ar_seen + 1;
      end
      if (inst_valid && inst_ready)
        got.push_back(inst_pkt);
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES)
    begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {6'h05, addr[25:0] ^ addr[31:6]};
  endfunction

  // fill words are addi reading rj and writing rd
  function automatic fe_pkg::fetch_pkt_t fill_pkt(input logic [31:0] pc);
    fe_pkg::fetch_pkt_t p;
    p        = '0;
    p.pc     = pc;
    p.inst   = fill_word(pc);
    p.op     = fe_pkg::OP_ADDI;
    p.ri.rs0 = p.inst[9:5];
    p.ri.rd  = p.inst[4:0];
    return p;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors = errors + 1;
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
  endtask

  task automatic check_ar(input fe_pkg::axil_ar_t act);
    checks = checks + 1;
    if (act.prot !== 3'b000)
      report_mismatch("m_ar_o.prot", 32'h0, 32'(act.prot));
  endtask

  task automatic check_pkt(input fe_pkg::fetch_pkt_t exp, input fe_pkg::fetch_pkt_t act);
    checks = checks + 1;
    if (act.pc !== exp.pc)
      report_mismatch("inst_pkt_o.pc", exp.pc, act.pc);
    if (act.inst !== exp.inst)
      report_mismatch("inst_pkt_o.inst", exp.inst, act.inst);
    if (act.op !== exp.op)
      report_mismatch("inst_pkt_o.op", 32'(exp.op), 32'(act.op));
    if (act.ri !== exp.ri)
      report_mismatch("inst_pkt_o.ri", 32'(exp.ri), 32'(act.ri));
    if (act.ine !== exp.ine)
      report_mismatch("inst_pkt_o.ine", 32'(exp.ine), 32'(act.ine));
    if (act.ferr !== exp.ferr)
      report_mismatch("inst_pkt_o.ferr", 32'(exp.ferr), 32'(act.ferr));
  endtask

  task automatic check_op(input fe_pkg::op_e exp, input fe_pkg::op_e act);
    checks = checks + 1;
    if (act !== exp)
    begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: inst_pkt_o.op expected %s, got %s",
               $time, exp.name(), act.name());
    end
  endtask

  // fields packed as {rk, rj, rd}
  // expected registers packed as {rs0, rs1, rd}
  task automatic add_case(input int idx, input logic [5:0] opc, input logic [14:0] fields,
                          input fe_pkg::op_e op, input fe_pkg::reg_info_t ri, input logic ine);
    fe_pkg::fetch_pkt_t exp;
    exp           = '0;
    exp.pc        = 32'h0000_0200 + 32'(4 * idx);
    exp.inst      = {opc, 11'b0, fields};
    exp.op        = op;
    exp.ri        = ri;
    exp.ine       = ine;
    case_exp[idx] = exp;
    i_axil_rom.prog[128 + idx] = exp.inst;
  endtask

  task automatic load_decode_cases();
    add_case(0, 6'h01, {5'd3, 5'd2, 5'd1}, fe_pkg::OP_ADD, {5'd2, 5'd3, 5'd1}, 1'b0);
    add_case(1, 6'h02, {5'd6, 5'd5, 5'd4}, fe_pkg::OP_SUB, {5'd5, 5'd6, 5'd4}, 1'b0);
    add_case(2, 6'h03, {5'd9, 5'd8, 5'd7}, fe_pkg::OP_AND, {5'd8, 5'd9, 5'd7}, 1'b0);
    add_case(3, 6'h04, {5'd12, 5'd11, 5'd10}, fe_pkg::OP_OR, {5'd11, 5'd12, 5'd10}, 1'b0);
    add_case(4, 6'h05, {5'd31, 5'd13, 5'd14}, fe_pkg::OP_ADDI, {5'd13, 5'd0, 5'd14}, 1'b0);
    add_case(5, 6'h06, {5'd0, 5'd15, 5'd16}, fe_pkg::OP_LD, {5'd15, 5'd0, 5'd16}, 1'b0);
    add_case(6, 6'h07, {5'd5, 5'd17, 5'd18}, fe_pkg::OP_ST, {5'd17, 5'd18, 5'd0}, 1'b0);
    add_case(7, 6'h08, {5'd0, 5'd19, 5'd20}, fe_pkg::OP_BEQ, {5'd19, 5'd20, 5'd0}, 1'b0);
    add_case(8, 6'h09, {5'd7, 5'd21, 5'd22}, fe_pkg::OP_BL, {5'd0, 5'd0, 5'd1}, 1'b0);
    add_case(9, 6'h3f, {5'd0, 5'd1, 5'd2}, fe_pkg::OP_NONE, {5'd0, 5'd0, 5'd0}, 1'b1);
  endtask

  task automatic wait_pkts(input int n);
    while (got.size() < n)
      @(negedge clk);
  endtask

  // flush with the output held and start a clean stream
  task automatic restart_at(input logic [31:0] target, input logic ready);
    @(negedge clk);
    inst_ready      = 1'b0;
    redirect.valid  = 1'b1;
    redirect.target = target;
    @(negedge clk);
    redirect.valid = 1'b0;
    got.delete();
    ar_seen    = 0;
    ar_floor   = target;
    inst_ready = ready;
  endtask

  task automatic stream_after_reset();
    wait_pkts(8);
    for (int i = 0; i < 8; i++)
      check_pkt(fill_pkt(RESET_PC + 32'(4 * i)), got[i]);
  endtask

  task automatic decode_all_opcodes();
    restart_at(32'h0000_0200, 1'b1);
    wait_pkts(10);
    for (int i = 0; i < 10; i++)
    begin
      check_op(case_exp[i].op, got[i].op);
      check_pkt(case_exp[i], got[i]);
    end
  endtask

  task automatic hold_ready_low();
    int inflight;
    int peak;
    peak = 0;
    restart_at(32'h0000_0300, 1'b0);
    for (int c = 0; c < 30 || got.size() < 12; c++)
    begin
      @(negedge clk);
      if (c == 29)
        inst_ready = 1'b1;
      inflight = ar_seen - got.size();
      if (inflight > peak)
        peak = inflight;
    end
    checks = checks + 1;
    if (peak > int'(QUEUE_DEPTH))
    begin
      errors = errors + 1;
      $display("at %0t: %0d reads were outstanding, more than the queue holds", $time, peak);
    end
    for (int i = 0; i < 12; i++)
      check_pkt(fill_pkt(32'h0000_0300 + 32'(4 * i)), got[i]);
  endtask

  task automatic redirect_in_flight();
    int base;
    restart_at(32'h0000_0400, 1'b1);
    wait_pkts(2);
    @(negedge clk);
    while (!rready)
      @(negedge clk);
    redirect.valid  = 1'b1;
    redirect.target = 32'h0000_0500;
    @(negedge clk);
    redirect.valid = 1'b0;
    base = got.size();
    wait_pkts(base + 4);
    for (int i = 0; i < 4; i++)
      check_pkt(fill_pkt(32'h0000_0500 + 32'(4 * i)), got[base + i]);
  endtask

  task automatic fetch_bus_error();
    fe_pkg::fetch_pkt_t exp;
    restart_at(32'h0000_0ffc, 1'b1);
    wait_pkts(5);
    check_pkt(fill_pkt(32'h0000_0ffc), got[0]);
    for (int i = 1; i < 5; i++)
    begin
      // error responses carry zero data from the memory model
      exp      = '0;
      exp.pc   = 32'h0000_0ffc + 32'(4 * i);
      exp.op   = fe_pkg::OP_NONE;
      exp.ferr = 1'b1;
      check_op(fe_pkg::OP_NONE, got[i].op);
      check_pkt(exp, got[i]);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    redirect   = '0;
    inst_ready = 1'b1;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    ar_seen    = 0;
    ar_floor   = '0;
    for (int i = 0; i < 1024; i++)
      i_axil_rom.prog[i] = fill_word(32'(i) << 2);
    load_decode_cases();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    stream_after_reset();
    decode_all_opcodes();
    hold_ready_low();
    redirect_in_flight();
    fetch_bus_error();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/fe_pkg.sv
logic/fetch_ctrl.sv
logic/slot_credit.sv
logic/inst_decode.sv
logic/inst_queue.sv
logic/fe_top.sv
verification/axil_rom_model.sv
verification/tb_fe_top.sv

//--- Makefile
TOP = tb_fe_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation ended without a result line"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
